//--- core_pkg.sv
/*
 * Shared types, field widths and small helpers of the four-strand scalar pipeline.
 * Stages import it for instruction fields, data words and round-robin picking.
 */
package core_pkg;
	localparam int WORD_W = 32;	// Data and instruction word
	localparam int PC_W = 16;	// PC counts instruction words
	localparam int REG_IDX_W = 3;
	localparam int NUM_REGS = 1 << REG_IDX_W;	// Registers per strand
	localparam int OPCODE_W = 4;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [PC_W-1:0] pc_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Instruction bits 31:28
	typedef enum logic [OPCODE_W-1:0] {
		op_add,		// dest = src1 + src2
		op_sub,		// dest = src1 - src2
		op_and,
		op_or,
		op_xor,
		op_addi,	// dest = src1 + imm
		op_bz,		// Branch to pc + imm if src1 is zero
		op_jmp,		// Always to pc + imm
		op_out,		// Output write of src1 at address imm
		op_stop		// Disables the issuing strand
	} opcode_t;

	// Ops with a register result
	function automatic logic is_alu(input opcode_t op);
		return op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi};
	endfunction

	// First ready bit at or after start, wrapping; -1 if none
	function automatic int rr_pick(input logic [31:0] ready, input int start, input int count);
		int pick;
		int idx;
		pick = -1;
		for (int i = 0; i < count; i++)
		begin
			idx = (start + i) % count;
			if (pick < 0 && ready[idx])
				pick = idx;
		end
		return pick;
	endfunction
endpackage

//--- instruction_fetch_stage.sv
/*
 * Fetch for all strands. One request per cycle through the instruction port,
 * round-robin over strands with an empty buffer, one buffer per strand.
 * A rollback reloads the PC and drops the strand's buffer and in-flight fetch.
 */
`timescale 1ns/1ps

module instruction_fetch_stage
	#(parameter int NUM_STRANDS = 4,
	parameter int STRAND_CODE_WORDS = 64,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	output logic icache_request,
	output core_pkg::pc_t icache_addr,
	input core_pkg::word_t icache_data,	// Valid the cycle after the request
	input logic [NUM_STRANDS-1:0] ss_instruction_req,
	input logic [NUM_STRANDS-1:0] cr_strand_enable,
	input logic ex_rollback_request,
	input logic [STRAND_W-1:0] ex_rollback_strand,
	input core_pkg::pc_t ex_rollback_pc,
	output logic [NUM_STRANDS-1:0] if_instruction_valid,
	output core_pkg::word_t [NUM_STRANDS-1:0] if_instruction,
	output core_pkg::pc_t [NUM_STRANDS-1:0] if_pc);

	import core_pkg::*;

	pc_t [NUM_STRANDS-1:0] pc;	// Next word to fetch per strand
	logic [NUM_STRANDS-1:0] pending;	// Request out, data not yet captured
	logic [NUM_STRANDS-1:0] rollback_mask;
	logic [NUM_STRANDS-1:0] candidate;
	logic [STRAND_W-1:0] rr_ptr;
	logic [STRAND_W-1:0] req_strand;	// Strand of the request on the port
	logic resp_valid;	// icache_data holds a live word
	logic [STRAND_W-1:0] resp_strand;
	logic capture;
	int pick;

	always_comb
	begin
		rollback_mask = '0;
		if (ex_rollback_request)
			rollback_mask[ex_rollback_strand] = 1'b1;
	end

	assign candidate = cr_strand_enable & ~if_instruction_valid & ~pending & ~rollback_mask;
	assign pick = rr_pick(32'(candidate), int'(rr_ptr), NUM_STRANDS);
	assign capture = resp_valid && !rollback_mask[resp_strand];	// Squashed if rolled back

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			icache_request <= 1'b0;
			resp_valid <= 1'b0;
			req_strand <= '0;
			resp_strand <= '0;
			rr_ptr <= '0;
			pending <= '0;
			if_instruction_valid <= '0;
			for (int s = 0; s < NUM_STRANDS; s++)
				pc[s] <= pc_t'(s * STRAND_CODE_WORDS);	// Each strand at its own code slot
		end
		else
		begin
			icache_request <= pick >= 0;
			resp_valid <= icache_request && !rollback_mask[req_strand];
			resp_strand <= req_strand;
			pending <= pending & ~rollback_mask;
			if_instruction_valid <= if_instruction_valid & ~ss_instruction_req & ~rollback_mask;
			if (pick >= 0)
			begin
				req_strand <= STRAND_W'(pick);
				rr_ptr <= STRAND_W'((pick + 1) % NUM_STRANDS);
				pending[pick] <= 1'b1;
			end
			if (capture)
			begin
				pending[resp_strand] <= 1'b0;
				if_instruction_valid[resp_strand] <= 1'b1;
				pc[resp_strand] <= pc[resp_strand] + 1'b1;
			end
			if (ex_rollback_request)
				pc[ex_rollback_strand] <= ex_rollback_pc;	// Redirect wins
		end
	end

	always_ff @(posedge clk)
	begin
		if (pick >= 0)
			icache_addr <= pc[pick];
		if (capture)
		begin
			if_instruction[resp_strand] <= icache_data;
			if_pc[resp_strand] <= pc[resp_strand];	// PC holds until capture
		end
	end
endmodule

//--- strand_select_stage.sv
/*
 * Issues at most one instruction per cycle from the full fetch buffers of
 * enabled strands, round-robin, and pulses the request that empties the buffer.
 */
`timescale 1ns/1ps

module strand_select_stage
	#(parameter int NUM_STRANDS = 4,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	input logic [NUM_STRANDS-1:0] if_instruction_valid,
	input core_pkg::word_t [NUM_STRANDS-1:0] if_instruction,
	input core_pkg::pc_t [NUM_STRANDS-1:0] if_pc,
	input logic [NUM_STRANDS-1:0] cr_strand_enable,
	input logic ex_rollback_request,
	input logic [STRAND_W-1:0] ex_rollback_strand,
	output logic [NUM_STRANDS-1:0] ss_instruction_req,
	output logic ss_valid,
	output core_pkg::word_t ss_instruction,
	output core_pkg::pc_t ss_pc,
	output logic [STRAND_W-1:0] ss_strand);

	import core_pkg::*;

	logic [NUM_STRANDS-1:0] ready;
	logic [STRAND_W-1:0] rr_ptr;
	int pick;

	always_comb
	begin
		ready = if_instruction_valid & cr_strand_enable;
		if (ex_rollback_request)
			ready[ex_rollback_strand] = 1'b0;	// Buffer is wrong path
	end

	assign pick = rr_pick(32'(ready), int'(rr_ptr), NUM_STRANDS);

	always_comb
	begin
		ss_instruction_req = '0;
		if (pick >= 0)
			ss_instruction_req[pick] = 1'b1;	// Frees the buffer on this edge
	end

	// A registered instruction of a rolled-back strand is dropped by decode
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ss_valid <= 1'b0;
			rr_ptr <= '0;
		end
		else
		begin
			ss_valid <= pick >= 0;
			if (pick >= 0)
				rr_ptr <= STRAND_W'((pick + 1) % NUM_STRANDS);
		end
	end

	always_ff @(posedge clk)
	begin
		if (pick >= 0)
		begin
			ss_instruction <= if_instruction[pick];
			ss_pc <= if_pc[pick];
			ss_strand <= STRAND_W'(pick);
		end
	end
endmodule

//--- decode_stage.sv
/*
 * Splits the issued instruction into fields, drives the register file read
 * selects and registers the decoded instruction with both read values.
 */
`timescale 1ns/1ps

module decode_stage
	#(parameter int NUM_STRANDS = 4,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	input logic ss_valid,
	input core_pkg::word_t ss_instruction,
	input core_pkg::pc_t ss_pc,
	input logic [STRAND_W-1:0] ss_strand,
	input core_pkg::word_t scalar_value1,
	input core_pkg::word_t scalar_value2,
	input logic ex_rollback_request,
	input logic [STRAND_W-1:0] ex_rollback_strand,
	output core_pkg::reg_idx_t ds_sel1,
	output core_pkg::reg_idx_t ds_sel2,
	output logic ds_valid,
	output core_pkg::opcode_t ds_op,
	output core_pkg::reg_idx_t ds_dest,
	output core_pkg::reg_idx_t ds_src1,
	output core_pkg::reg_idx_t ds_src2,
	output core_pkg::word_t ds_immediate,
	output core_pkg::pc_t ds_pc,
	output logic [STRAND_W-1:0] ds_strand,
	output core_pkg::word_t ds_value1,
	output core_pkg::word_t ds_value2);

	import core_pkg::*;

	logic squash;

	assign ds_sel1 = ss_instruction[24:22];	// Source 1
	assign ds_sel2 = ss_instruction[21:19];	// Source 2
	assign squash = ex_rollback_request && ex_rollback_strand == ss_strand;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			ds_valid <= 1'b0;
		else
			ds_valid <= ss_valid && !squash;	// Younger than the branch in execute
	end

	always_ff @(posedge clk)
	begin
		ds_op <= opcode_t'(ss_instruction[31:28]);
		ds_dest <= ss_instruction[27:25];
		ds_src1 <= ds_sel1;
		ds_src2 <= ds_sel2;
		ds_immediate <= {{16{ss_instruction[15]}}, ss_instruction[15:0]};	// Sign extended
		ds_pc <= ss_pc;
		ds_strand <= ss_strand;
		ds_value1 <= scalar_value1;	// May be stale; execute bypasses
		ds_value2 <= scalar_value2;
	end
endmodule

//--- scalar_register_file.sv
/*
 * Eight scalar registers per strand. Two combinational read ports indexed by
 * the strand in decode, one write port from memory access on the clock edge.
 */
`timescale 1ns/1ps

module scalar_register_file
	#(parameter int NUM_STRANDS = 4,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	input core_pkg::reg_idx_t ds_sel1,
	input core_pkg::reg_idx_t ds_sel2,
	input logic [STRAND_W-1:0] ss_strand,
	input logic ma_write_en,
	input logic [STRAND_W-1:0] ma_strand,
	input core_pkg::reg_idx_t ma_dest,
	input core_pkg::word_t ma_result,
	output core_pkg::word_t scalar_value1,
	output core_pkg::word_t scalar_value2);

	import core_pkg::*;

	word_t regs [NUM_STRANDS][NUM_REGS];

	assign scalar_value1 = regs[ss_strand][ds_sel1];
	assign scalar_value2 = regs[ss_strand][ds_sel2];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				for (int r = 0; r < NUM_REGS; r++)
					regs[s][r] <= '0;	// Programs start from zeroed registers
		end
		else if (ma_write_en)
			regs[ma_strand][ma_dest] <= ma_result;
	end
endmodule

//--- execute_stage.sv
/*
 * Execute: picks bypassed operands, runs the ALU and resolves branches and
 * stops. A taken branch or a stop raises a rollback for its strand in the same
 * cycle; results go to memory access through the ex register.
 */
`timescale 1ns/1ps

module execute_stage
	#(parameter int NUM_STRANDS = 4,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	input logic ds_valid,
	input core_pkg::opcode_t ds_op,
	input core_pkg::reg_idx_t ds_dest,
	input core_pkg::reg_idx_t ds_src1,
	input core_pkg::reg_idx_t ds_src2,
	input core_pkg::word_t ds_immediate,
	input core_pkg::pc_t ds_pc,
	input logic [STRAND_W-1:0] ds_strand,
	input core_pkg::word_t ds_value1,
	input core_pkg::word_t ds_value2,
	input logic ma_write_en,
	input logic [STRAND_W-1:0] ma_strand,
	input core_pkg::reg_idx_t ma_dest,
	input core_pkg::word_t ma_result,
	input logic rf_write_en,
	input logic [STRAND_W-1:0] rf_strand,
	input core_pkg::reg_idx_t rf_dest,
	input core_pkg::word_t rf_result,
	output logic ex_valid,
	output core_pkg::opcode_t ex_op,
	output core_pkg::reg_idx_t ex_dest,
	output logic [STRAND_W-1:0] ex_strand,
	output core_pkg::word_t ex_result,
	output core_pkg::word_t ex_store_value,
	output core_pkg::word_t ex_address,
	output logic ex_rollback_request,
	output logic [STRAND_W-1:0] ex_rollback_strand,
	output core_pkg::pc_t ex_rollback_pc,
	output logic ex_stop);

	import core_pkg::*;

	logic ex_writes;
	logic branch_taken;
	word_t operand1;
	word_t operand2;
	word_t alu_result;

	assign ex_writes = ex_valid && is_alu(ex_op);

	// Youngest in-flight result first, register read last
	function automatic word_t bypass(input reg_idx_t src, input word_t read_value);
		if (ex_writes && ex_strand == ds_strand && ex_dest == src)
			return ex_result;
		else if (ma_write_en && ma_strand == ds_strand && ma_dest == src)
			return ma_result;
		else if (rf_write_en && rf_strand == ds_strand && rf_dest == src)
			return rf_result;	// Written after decode read the file
		return read_value;
	endfunction

	always_comb
	begin
		operand1 = bypass(ds_src1, ds_value1);
		operand2 = bypass(ds_src2, ds_value2);
		case (ds_op)
			op_add: alu_result = operand1 + operand2;
			op_sub: alu_result = operand1 - operand2;
			op_and: alu_result = operand1 & operand2;
			op_or: alu_result = operand1 | operand2;
			op_xor: alu_result = operand1 ^ operand2;
			op_addi: alu_result = operand1 + ds_immediate;
			default: alu_result = operand1;	// No register result
		endcase
	end

	assign branch_taken = ds_valid && (ds_op == op_jmp || (ds_op == op_bz && operand1 == '0));
	assign ex_stop = ds_valid && ds_op == op_stop;
	assign ex_rollback_request = branch_taken || ex_stop;
	assign ex_rollback_strand = ds_strand;
	assign ex_rollback_pc = ex_stop ? ds_pc : ds_pc + ds_immediate[15:0];	// Stop parks on itself

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= ds_valid;
	end

	always_ff @(posedge clk)
	begin
		ex_op <= ds_op;
		ex_dest <= ds_dest;
		ex_strand <= ds_strand;
		ex_result <= alu_result;
		ex_store_value <= operand1;	// Output data
		ex_address <= ds_immediate;	// Output address
	end
endmodule

//--- memory_access_stage.sv
/*
 * Memory access with writeback folded in. Pulses the uncached output write,
 * drives the register file write port and keeps a one-cycle delayed copy of
 * the writeback for the execute bypass.
 */
`timescale 1ns/1ps

module memory_access_stage
	#(parameter int NUM_STRANDS = 4,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	input logic ex_valid,
	input core_pkg::opcode_t ex_op,
	input core_pkg::reg_idx_t ex_dest,
	input logic [STRAND_W-1:0] ex_strand,
	input core_pkg::word_t ex_result,
	input core_pkg::word_t ex_store_value,
	input core_pkg::word_t ex_address,
	output logic io_write_en,
	output core_pkg::word_t io_address,
	output core_pkg::word_t io_write_data,
	output logic [STRAND_W-1:0] io_req_strand,
	output logic ma_write_en,
	output logic [STRAND_W-1:0] ma_strand,
	output core_pkg::reg_idx_t ma_dest,
	output core_pkg::word_t ma_result,
	output logic rf_write_en,
	output logic [STRAND_W-1:0] rf_strand,
	output core_pkg::reg_idx_t rf_dest,
	output core_pkg::word_t rf_result);

	import core_pkg::*;

	assign io_req_strand = ma_strand;	// Same instruction as the write

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			io_write_en <= 1'b0;
			ma_write_en <= 1'b0;
			rf_write_en <= 1'b0;
		end
		else
		begin
			io_write_en <= ex_valid && ex_op == op_out;	// One cycle pulse
			ma_write_en <= ex_valid && is_alu(ex_op);
			rf_write_en <= ma_write_en;	// Covers the register read gap
		end
	end

	always_ff @(posedge clk)
	begin
		io_address <= ex_address;
		io_write_data <= ex_store_value;
		ma_strand <= ex_strand;
		ma_dest <= ex_dest;
		ma_result <= ex_result;
		rf_strand <= ma_strand;
		rf_dest <= ma_dest;
		rf_result <= ma_result;
	end
endmodule

//--- control_registers.sv
/*
 * Strand enable mask, all strands on after reset. A stop clears its strand's
 * bit; halt is raised once no strand is left enabled and holds until reset.
 */
`timescale 1ns/1ps

module control_registers
	#(parameter int NUM_STRANDS = 4,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	input logic ex_stop,
	input logic [STRAND_W-1:0] ex_strand,
	output logic [NUM_STRANDS-1:0] cr_strand_enable,
	output logic halt);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			cr_strand_enable <= '1;
			halt <= 1'b0;
		end
		else
		begin
			if (ex_stop)
				cr_strand_enable[ex_strand] <= 1'b0;
			halt <= ~|cr_strand_enable;	// A cycle after the last stop lands
		end
	end
endmodule

//--- pipeline.sv
/*
 * Top of the four-strand scalar pipeline. Wires fetch, strand select, decode,
 * execute and memory access with the register file and control registers.
 * Instruction memory and output writes are external ports.
 */
`timescale 1ns/1ps

module pipeline
	#(parameter int NUM_STRANDS = 4,
	parameter int STRAND_CODE_WORDS = 64,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	output logic icache_request,
	output core_pkg::pc_t icache_addr,
	input core_pkg::word_t icache_data,
	output logic io_write_en,
	output core_pkg::word_t io_address,
	output core_pkg::word_t io_write_data,
	output logic [STRAND_W-1:0] io_req_strand,
	output logic halt);

	import core_pkg::*;

	logic [NUM_STRANDS-1:0] if_instruction_valid;
	word_t [NUM_STRANDS-1:0] if_instruction;
	pc_t [NUM_STRANDS-1:0] if_pc;
	logic [NUM_STRANDS-1:0] ss_instruction_req;
	logic [NUM_STRANDS-1:0] cr_strand_enable;
	logic ss_valid;
	word_t ss_instruction;
	pc_t ss_pc;
	logic [STRAND_W-1:0] ss_strand;
	reg_idx_t ds_sel1, ds_sel2;
	word_t scalar_value1, scalar_value2;
	logic ds_valid;
	opcode_t ds_op;
	reg_idx_t ds_dest, ds_src1, ds_src2;
	word_t ds_immediate, ds_value1, ds_value2;
	pc_t ds_pc;
	logic [STRAND_W-1:0] ds_strand;
	logic ex_valid, ex_rollback_request, ex_stop;
	opcode_t ex_op;
	reg_idx_t ex_dest;
	logic [STRAND_W-1:0] ex_strand, ex_rollback_strand;
	word_t ex_result, ex_store_value, ex_address;
	pc_t ex_rollback_pc;
	logic ma_write_en, rf_write_en;
	logic [STRAND_W-1:0] ma_strand, rf_strand;
	reg_idx_t ma_dest, rf_dest;
	word_t ma_result, rf_result;

	instruction_fetch_stage #(
		.NUM_STRANDS(NUM_STRANDS),
		.STRAND_CODE_WORDS(STRAND_CODE_WORDS)
	) instruction_fetch_stage (.*);

	strand_select_stage #(.NUM_STRANDS(NUM_STRANDS)) strand_select_stage (.*);

	decode_stage #(.NUM_STRANDS(NUM_STRANDS)) decode_stage (.*);

	scalar_register_file #(.NUM_STRANDS(NUM_STRANDS)) scalar_register_file (.*);

	execute_stage #(.NUM_STRANDS(NUM_STRANDS)) execute_stage (.*);

	memory_access_stage #(.NUM_STRANDS(NUM_STRANDS)) memory_access_stage (.*);

	// Stop resolves with its rollback, so the strand is the one in execute now
	control_registers #(.NUM_STRANDS(NUM_STRANDS)) control_registers (
		.ex_strand(ex_rollback_strand),
		.*);
endmodule

//--- pipeline_checker.sv
/*
 * Concurrent assertions on the pipeline top, attached by bind from the testbench.
 * Covers reset behavior of the output port, fetch after halt and halt stickiness.
 */
`timescale 1ns/1ps

module pipeline_checker
	(input logic clk,
	input logic reset,
	input logic io_write_en,
	input logic icache_request,
	input logic halt);

	// Output port stays quiet while reset is held
	assert property (@(posedge clk) reset |-> !io_write_en)
		else $error("output write during reset");

	// Nothing is left to fetch once halted
	assert property (@(posedge clk) disable iff (reset) halt |-> !icache_request)
		else $error("instruction request while halted");

	// Only reset brings halt back down
	assert property (@(posedge clk) $fell(halt) |-> reset)
		else $error("halt fell without reset");
endmodule

//--- pipeline_monitor.sv
/*
 * Watches the output port and halt of the pipeline. The testbench loads the
 * expected writes per strand; each write pops its strand's queue and compares.
 * At halt every queue must be empty.
 */
`timescale 1ns/1ps

module pipeline_monitor
	#(parameter int NUM_STRANDS = 4,
	localparam int STRAND_W = $clog2(NUM_STRANDS))
	(input logic clk,
	input logic reset,
	input logic io_write_en,
	input core_pkg::word_t io_address,
	input core_pkg::word_t io_write_data,
	input logic [STRAND_W-1:0] io_req_strand,
	input logic halt);

	import core_pkg::*;

	word_t exp_addr [NUM_STRANDS][$];	// Expected writes in program order
	word_t exp_data [NUM_STRANDS][$];
	word_t want_addr;
	word_t want_data;
	int error_count = 0;
	int write_count = 0;
	logic halt_prev = 1'b0;

	function void clear_queues();
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			exp_addr[s].delete();
			exp_data[s].delete();
		end
	endfunction

	function void expect_write(input int strand, input word_t addr, input word_t data);
		exp_addr[strand].push_back(addr);
		exp_data[strand].push_back(data);
	endfunction

	// Outputs are settled at the falling edge
	always @(negedge clk)
	begin
		if (reset)
			halt_prev = 1'b0;
		else
		begin
			if (io_write_en)
			begin
				write_count++;
				if (halt)
				begin
					$display("output write from strand %0d after halt at %0t", io_req_strand, $time);
					error_count++;
				end
				if (exp_addr[io_req_strand].size() == 0)
				begin
					$display("strand %0d wrote to the output port with nothing expected at %0t",
						io_req_strand, $time);
					error_count++;
				end
				else
				begin
					want_addr = exp_addr[io_req_strand].pop_front();
					want_data = exp_data[io_req_strand].pop_front();
					if (want_addr !== io_address || want_data !== io_write_data)
					begin
						$display("mismatch at %0t: strand %0d wrote %h to %h, expected %h to %h",
							$time, io_req_strand, io_write_data, io_address, want_data, want_addr);
						error_count++;
					end
				end
			end
			if (halt && !halt_prev)
			begin
				for (int s = 0; s < NUM_STRANDS; s++)
					if (exp_addr[s].size() != 0)
					begin
						$display("halt rose while strand %0d still owed %0d output writes",
							s, exp_addr[s].size());
						error_count++;
					end
			end
			halt_prev = halt;
		end
	end
endmodule

//--- tb_pipeline.sv
/*
 * Testbench for the four-strand pipeline. Holds the program ROM behind the
 * instruction port, runs a serial reference of every strand to build the
 * expected output writes, and runs each test from reset to halt.
 */
`timescale 1ns/1ps

module tb_pipeline;
	import core_pkg::*;

	localparam int NUM_STRANDS = 4;
	localparam int CODE_WORDS = 64;
	localparam int ROM_WORDS = NUM_STRANDS * CODE_WORDS;

	logic clk;
	logic reset;
	logic icache_request;
	pc_t icache_addr;
	word_t icache_data;
	logic io_write_en;
	word_t io_address;
	word_t io_write_data;
	logic [$clog2(NUM_STRANDS)-1:0] io_req_strand;
	logic halt;

	word_t rom [ROM_WORDS];
	logic req_seen = 1'b0;
	pc_t req_addr = '0;
	int cycle_count = 0;
	int deadline = 1000;	// In cycles and raised by each test
	int failed_tests = 0;
	int passed_tests = 0;

	pipeline #(.NUM_STRANDS(NUM_STRANDS), .STRAND_CODE_WORDS(CODE_WORDS)) UUT (.*);

	pipeline_monitor #(.NUM_STRANDS(NUM_STRANDS)) monitor (.*);

	bind pipeline pipeline_checker pipeline_checker_inst (.clk(clk), .reset(reset),
		.io_write_en(io_write_en), .icache_request(icache_request), .halt(halt));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	always @(posedge clk)
		cycle_count++;

	// One-cycle instruction memory latches the request and answers after the next edge
	always @(negedge clk)
	begin
		req_seen = icache_request;
		req_addr = icache_addr;
	end

	always @(posedge clk)
	begin
		#1;
		if (req_seen)
			icache_data = rom[int'(req_addr) % ROM_WORDS];
	end

	initial
	begin
		wait (cycle_count > deadline);
		$display("timeout: no halt after %0d cycles", cycle_count);
		$display(">>> FAIL");
		$finish;
	end

	function automatic word_t encode(input opcode_t op, input int d, input int s1, input int s2,
		input int imm);
		return {op, 3'(d), 3'(s1), 3'(s2), 3'b000, 16'(imm)};
	endfunction

	function automatic void put(input int strand, input int idx, input word_t instr);
		rom[strand * CODE_WORDS + idx] = instr;
	endfunction

	// Unused words are stops; the low half carries the address
	function automatic void clear_rom();
		for (int a = 0; a < ROM_WORDS; a++)
			rom[a] = {op_stop, 12'h000, 16'(a)};
	endfunction

	// Serial interpretation of one strand, fills the monitor's queue
	function automatic int run_reference(input int strand);
		word_t regs [NUM_REGS];
		word_t instr;
		word_t imm;
		word_t a;
		word_t b;
		opcode_t op;
		pc_t pc;
		int d;
		int count;
		for (int r = 0; r < NUM_REGS; r++)
			regs[r] = '0;
		pc = pc_t'(strand * CODE_WORDS);
		count = 0;
		while (count < 2000)
		begin
			instr = rom[int'(pc) % ROM_WORDS];
			op = opcode_t'(instr[31:28]);
			d = int'(instr[27:25]);
			a = regs[int'(instr[24:22])];
			b = regs[int'(instr[21:19])];
			imm = {{16{instr[15]}}, instr[15:0]};
			count++;
			if (op == op_stop)
				break;
			case (op)
				op_add: regs[d] = a + b;
				op_sub: regs[d] = a - b;
				op_and: regs[d] = a & b;
				op_or: regs[d] = a | b;
				op_xor: regs[d] = a ^ b;
				op_addi: regs[d] = a + imm;
				op_out: monitor.expect_write(strand, imm, a);
				default: ;
			endcase
			if (op == op_jmp || (op == op_bz && a == '0))
				pc = pc + imm[15:0];
			else
				pc = pc + 16'd1;
		end
		return count;
	endfunction

	task automatic run_test(input int num, input string name);
		int count;
		int errs_before;
		int writes_before;
		int errs;
		monitor.clear_queues();
		count = 0;
		for (int s = 0; s < NUM_STRANDS; s++)
			count += run_reference(s);
		deadline = cycle_count + 5 * count + 316;	// Reset plus slack
		errs_before = monitor.error_count;
		writes_before = monitor.write_count;
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (16) @(posedge clk);
		#1 reset = 1'b0;
		while (!halt)
			@(negedge clk);
		repeat (8) @(posedge clk);	// Any late write shows up here
		errs = monitor.error_count - errs_before;
		if (errs == 0)
			passed_tests++;
		else
			failed_tests++;
		$display("test %0d %s: %s, %0d instructions, %0d writes, %0d errors", num, name,
			errs == 0 ? "ok" : "failed", count, monitor.write_count - writes_before, errs);
	endtask

	task automatic load_chain();
		clear_rom();
		put(0, 0, encode(op_addi, 1, 0, 0, 7));
		put(0, 1, encode(op_add, 2, 1, 1, 0));	// Back to back on r1
		put(0, 2, encode(op_sub, 3, 2, 1, 0));
		put(0, 3, encode(op_xor, 4, 3, 2, 0));
		put(0, 4, encode(op_or, 5, 4, 1, 0));
		put(0, 5, encode(op_and, 6, 5, 2, 0));
		put(0, 6, encode(op_out, 0, 6, 0, 'h100));
		put(0, 7, encode(op_addi, 7, 6, 0, -3));
		put(0, 8, encode(op_out, 0, 7, 0, 'h101));
		put(0, 9, encode(op_add, 1, 7, 4, 0));
		put(0, 10, encode(op_out, 0, 1, 0, 'h102));
		put(0, 11, encode(op_out, 0, 4, 0, 'h103));
	endtask

	task automatic load_countdown();
		clear_rom();
		put(0, 0, encode(op_addi, 1, 0, 0, 5));
		put(0, 1, encode(op_out, 0, 1, 0, 'h10));
		put(0, 2, encode(op_addi, 1, 1, 0, -1));
		put(0, 3, encode(op_bz, 0, 1, 0, 2));	// Exit to 5
		put(0, 4, encode(op_jmp, 0, 0, 0, -3));	// Back to 1
		put(0, 5, encode(op_addi, 2, 0, 0, 'h77));
		put(0, 6, encode(op_out, 0, 2, 0, 'h20));
	endtask

	task automatic load_interleave();
		clear_rom();
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			put(s, 0, encode(op_addi, 1, 0, 0, (s + 1) * 3));	// Loop count
			put(s, 1, encode(op_addi, 2, 0, 0, s * 100));
			put(s, 2, encode(op_add, 2, 2, 1, 0));
			put(s, 3, encode(op_out, 0, 2, 0, s * 16 + 1));
			put(s, 4, encode(op_addi, 1, 1, 0, -1));
			put(s, 5, encode(op_bz, 0, 1, 0, 2));
			put(s, 6, encode(op_jmp, 0, 0, 0, -4));
			put(s, 7, encode(op_out, 0, 2, 0, s * 16 + 2));
		end
	endtask

	task automatic load_random();
		int len;
		int kind;
		int off;
		clear_rom();
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			len = 12 + int'($urandom % 8);	// Stop sits at len
			for (int i = 0; i < len; i++)
			begin
				kind = int'($urandom % 10);
				off = 1 + int'($urandom % 3);
				if (i + off > len)
					off = len - i;	// Forward only and never past the stop
				if (kind < 6)
					put(s, i, encode(opcode_t'(4'($urandom % 6)), int'($urandom % 8),
						int'($urandom % 8), int'($urandom % 8), int'($urandom % 65536)));
				else if (kind == 6)
					put(s, i, encode(op_bz, 0, int'($urandom % 8), 0, off));
				else if (kind == 7)
					put(s, i, encode(op_jmp, 0, 0, 0, off));
				else
					put(s, i, encode(op_out, 0, int'($urandom % 8), 0, int'($urandom % 65536)));
			end
		end
	endtask

	task automatic load_staggered_stop();
		clear_rom();
		for (int s = 0; s < NUM_STRANDS; s++)
			for (int k = 0; k < s * 3 + 1; k++)
			begin
				put(s, 2 * k, encode(op_addi, 1, 1, 0, s + 1));
				put(s, 2 * k + 1, encode(op_out, 0, 1, 0, s * 64 + k));
			end
	endtask

	initial
	begin
		reset = 1'b1;
		icache_data = '0;
		void'($urandom(54));
		load_chain();
		run_test(1, "dependent chain");
		load_countdown();
		run_test(2, "countdown loop");
		load_interleave();
		run_test(3, "interleaving");
		for (int n = 0; n < 3; n++)
		begin
			load_random();
			run_test(4, "random program");
		end
		load_staggered_stop();
		run_test(5, "halt");
		$display("tests passed %0d, failed %0d, monitor errors %0d", passed_tests, failed_tests,
			monitor.error_count);
		if (failed_tests == 0 && monitor.error_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end
endmodule

//--- list.f
core_pkg.sv
instruction_fetch_stage.sv
strand_select_stage.sv
decode_stage.sv
scalar_register_file.sv
execute_stage.sv
memory_access_stage.sv
control_registers.sv
pipeline.sv
pipeline_checker.sv
pipeline_monitor.sv
tb_pipeline.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
verilator --binary --timing -Wno-fatal --top-module tb_pipeline -f list.f \
	-o tb_pipeline_sim \
	&& ./obj_dir/tb_pipeline_sim | tee /dev/stderr | grep -q '^>>> PASS$' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
